/* hw/apb_bus_pkg.sv */
// ====================
// APB bus widths, region map and the transfer FSM encodings
// Referenced by scoped name from the bus-facing modules
// ====================

package apb_bus_pkg;

   localparam int unsigned APB_ADDR_WIDTH = 12;
   localparam int unsigned APB_DATA_WIDTH = 32;

   // Region is picked by address bits 11:8
   localparam logic [11:0] GPIO_BASE    = 12'h000;
   localparam logic [11:0] PWM_BASE     = 12'h100;
   localparam logic [11:0] SOCCTRL_BASE = 12'h200;

   typedef enum logic [1:0] {IDLE, SETUP, ACCESS} apb_state_e;

   typedef enum logic {OP_READ, OP_WRITE} apb_op_e;

   typedef enum logic [1:0] {REG_NONE, REG_GPIO, REG_PWM, REG_SOCCTRL} region_e;

endpackage

/* hw/periph_reg_pkg.sv */
// ====================
// Register offsets and reset values of the peripheral regions
// ====================

package periph_reg_pkg;

   // GPIO region
   localparam logic [7:0] GPIO_DIR_OFS = 8'h00;
   localparam logic [7:0] GPIO_OUT_OFS = 8'h04;
   localparam logic [7:0] GPIO_IN_OFS  = 8'h08;

   // PWM region, channel n duty at DUTY + 4n
   localparam logic [7:0] PWM_CTRL_OFS   = 8'h00;
   localparam logic [7:0] PWM_PERIOD_OFS = 8'h04;
   localparam logic [7:0] PWM_DUTY_OFS   = 8'h08;

   // SoC control region
   localparam logic [7:0] SOC_CLUSTER_OFS   = 8'h00;
   localparam logic [7:0] SOC_LLC_START_OFS = 8'h04;
   localparam logic [7:0] SOC_LLC_END_OFS   = 8'h08;
   localparam logic [7:0] SOC_SPM_START_OFS = 8'h0C;

   localparam logic [31:0] LLC_RESET_VALUE = 32'h0000_0000;

endpackage

/* hw/apb_xfer_fsm.sv */
// ====================
// APB slave FSM with zero wait states
// Decodes the region, drives per-block write strobes and muxes read data
// ====================
`timescale 1ns/1ps

module apb_xfer_fsm (
   input  logic                                    clk_i,
   input  logic                                    rst_n_i,
   input  logic [apb_bus_pkg::APB_ADDR_WIDTH-1:0]  paddr_i,
   input  logic                                    psel_i,
   input  logic                                    penable_i,
   input  logic                                    pwrite_i,
   input  logic [apb_bus_pkg::APB_DATA_WIDTH-1:0]  pwdata_i,
   input  logic [31:0]                             gpio_rdata_i,
   input  logic [31:0]                             pwm_rdata_i,
   input  logic [31:0]                             soc_rdata_i,
   output logic [apb_bus_pkg::APB_DATA_WIDTH-1:0]  prdata_o,
   output logic                                    pready_o,
   output logic                                    pslverr_o,
   output logic [7:0]                              reg_offset_o,
   output logic [31:0]                             reg_wdata_o,
   output logic                                    gpio_we_o,
   output logic                                    pwm_we_o,
   output logic                                    soc_we_o
);

   // Phase seen in the previous bus cycle
   apb_bus_pkg::apb_state_e state_q, state_d;
   apb_bus_pkg::region_e    region_q, region_d;
   apb_bus_pkg::apb_op_e    op_q;
   logic                    access;
   logic                    wr_access;

   always_comb begin
      state_d = state_q;
      case (state_q)
         apb_bus_pkg::IDLE: begin
            if (psel_i && !penable_i) state_d = apb_bus_pkg::SETUP;
         end
         apb_bus_pkg::SETUP: begin
            if (!psel_i) state_d = apb_bus_pkg::IDLE;
            else if (penable_i) state_d = apb_bus_pkg::ACCESS;
         end
         apb_bus_pkg::ACCESS: begin
            state_d = (psel_i && !penable_i) ? apb_bus_pkg::SETUP : apb_bus_pkg::IDLE;
         end
         default: state_d = apb_bus_pkg::IDLE;
      endcase
   end

   always_comb begin
      if (paddr_i[11:8] == apb_bus_pkg::GPIO_BASE[11:8]) region_d = apb_bus_pkg::REG_GPIO;
      else if (paddr_i[11:8] == apb_bus_pkg::PWM_BASE[11:8]) region_d = apb_bus_pkg::REG_PWM;
      else if (paddr_i[11:8] == apb_bus_pkg::SOCCTRL_BASE[11:8])
         region_d = apb_bus_pkg::REG_SOCCTRL;
      else region_d = apb_bus_pkg::REG_NONE;
   end

   always_ff @(posedge clk_i) begin
      if (!rst_n_i) state_q <= apb_bus_pkg::IDLE;
      else state_q <= state_d;
   end

   // Target and direction captured in the setup cycle
   always_ff @(posedge clk_i) begin
      if (state_d == apb_bus_pkg::SETUP) begin
         region_q <= region_d;
         op_q     <= pwrite_i ? apb_bus_pkg::OP_WRITE : apb_bus_pkg::OP_READ;
      end
   end

   assign access    = (state_q == apb_bus_pkg::SETUP) && psel_i && penable_i;
   assign wr_access = access && (op_q == apb_bus_pkg::OP_WRITE);

   assign pready_o     = access;
   assign pslverr_o    = access && (region_q == apb_bus_pkg::REG_NONE);
   assign reg_offset_o = paddr_i[7:0];
   assign reg_wdata_o  = pwdata_i;
   assign gpio_we_o    = wr_access && (region_q == apb_bus_pkg::REG_GPIO);
   assign pwm_we_o     = wr_access && (region_q == apb_bus_pkg::REG_PWM);
   assign soc_we_o     = wr_access && (region_q == apb_bus_pkg::REG_SOCCTRL);

   always_comb begin
      prdata_o = '0;
      if (access && op_q == apb_bus_pkg::OP_READ) begin
         case (region_q)
            apb_bus_pkg::REG_GPIO:    prdata_o = gpio_rdata_i;
            apb_bus_pkg::REG_PWM:     prdata_o = pwm_rdata_i;
            apb_bus_pkg::REG_SOCCTRL: prdata_o = soc_rdata_i;
            default:                  prdata_o = '0;
         endcase
      end
   end

endmodule

/* hw/pwm_timer.sv */
// ====================
// PWM timer, shared period counter with one duty compare per channel
// ====================
`timescale 1ns/1ps

module pwm_timer #(
   parameter int unsigned NUM_PWM       = 2,
   parameter int unsigned PWM_CNT_WIDTH = 16
) (
   input  logic               clk_i,
   input  logic               rst_n_i,
   input  logic               we_i,
   input  logic [7:0]         offset_i,
   input  logic [31:0]        wdata_i,
   output logic [31:0]        rdata_o,
   output logic [NUM_PWM-1:0] pwm_o
);

   logic                     en_q, en_d;
   logic [PWM_CNT_WIDTH-1:0] period_q;
   logic [PWM_CNT_WIDTH-1:0] cnt_q;
   logic [PWM_CNT_WIDTH-1:0] duty_q [NUM_PWM];
   logic [NUM_PWM-1:0]       pwm_q;

   function automatic logic [7:0] duty_ofs(input int ch);
      return periph_reg_pkg::PWM_DUTY_OFS + 8'(4 * ch);
   endfunction

   // Enable as it will be after this edge, so outputs drop right away
   assign en_d = (we_i && offset_i == periph_reg_pkg::PWM_CTRL_OFS) ? wdata_i[0] : en_q;

   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         en_q     <= 1'b0;
         period_q <= '0;
         cnt_q    <= '0;
         pwm_q    <= '0;
         for (int i = 0; i < NUM_PWM; i++) duty_q[i] <= '0;
      end else begin
         en_q <= en_d;
         if (we_i && offset_i == periph_reg_pkg::PWM_PERIOD_OFS)
            period_q <= wdata_i[PWM_CNT_WIDTH-1:0];
         for (int i = 0; i < NUM_PWM; i++) begin
            if (we_i && offset_i == duty_ofs(i)) duty_q[i] <= wdata_i[PWM_CNT_WIDTH-1:0];
         end
         // Wrap at period, hold at 0 while stopped
         if (!en_q || cnt_q >= period_q) cnt_q <= '0;
         else cnt_q <= cnt_q + 1'b1;
         for (int i = 0; i < NUM_PWM; i++) pwm_q[i] <= en_q && en_d && (cnt_q < duty_q[i]);
      end
   end

   always_comb begin
      rdata_o = '0;
      if (offset_i == periph_reg_pkg::PWM_CTRL_OFS) rdata_o = 32'(en_q);
      else if (offset_i == periph_reg_pkg::PWM_PERIOD_OFS) rdata_o = 32'(period_q);
      for (int i = 0; i < NUM_PWM; i++) begin
         if (offset_i == duty_ofs(i)) rdata_o = 32'(duty_q[i]);
      end
   end

   assign pwm_o = pwm_q;

endmodule

/* hw/gpio_regs.sv */
// ====================
// GPIO direction and output registers with synchronized pad inputs
// ====================
`timescale 1ns/1ps

module gpio_regs #(
   parameter int unsigned NUM_GPIO = 16
) (
   input  logic                clk_i,
   input  logic                rst_n_i,
   input  logic                we_i,
   input  logic [7:0]          offset_i,
   input  logic [31:0]         wdata_i,
   input  logic [NUM_GPIO-1:0] gpio_in_i,
   output logic [31:0]         rdata_o,
   output logic [NUM_GPIO-1:0] gpio_out_o,
   output logic [NUM_GPIO-1:0] gpio_oe_o
);

   logic [NUM_GPIO-1:0] dir_q;
   logic [NUM_GPIO-1:0] out_q;
   logic [NUM_GPIO-1:0] sync_q;
   logic [NUM_GPIO-1:0] in_q;

   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         dir_q <= '0;
         out_q <= '0;
      end else if (we_i) begin
         if (offset_i == periph_reg_pkg::GPIO_DIR_OFS) dir_q <= wdata_i[NUM_GPIO-1:0];
         if (offset_i == periph_reg_pkg::GPIO_OUT_OFS) out_q <= wdata_i[NUM_GPIO-1:0];
      end
   end

   // Two flop synchronizer for the pads
   always_ff @(posedge clk_i) begin
      sync_q <= gpio_in_i;
      in_q   <= sync_q;
   end

   always_comb begin
      case (offset_i)
         periph_reg_pkg::GPIO_DIR_OFS: rdata_o = 32'(dir_q);
         periph_reg_pkg::GPIO_OUT_OFS: rdata_o = 32'(out_q);
         periph_reg_pkg::GPIO_IN_OFS:  rdata_o = 32'(in_q);
         default:                      rdata_o = '0;
      endcase
   end

   // Pins set as inputs drive 0
   assign gpio_out_o = out_q & dir_q;
   assign gpio_oe_o  = dir_q;

endmodule

/* hw/soc_ctrl_regs.sv */
// ====================
// SoC control registers for cluster boot and LLC address windows
// ====================
`timescale 1ns/1ps

module soc_ctrl_regs (
   input  logic        clk_i,
   input  logic        rst_n_i,
   input  logic        we_i,
   input  logic [7:0]  offset_i,
   input  logic [31:0] wdata_i,
   output logic [31:0] rdata_o,
   output logic        cluster_fetch_en_o,
   output logic        cluster_rstn_o,
   output logic [31:0] llc_cache_addr_start_o,
   output logic [31:0] llc_cache_addr_end_o,
   output logic [31:0] llc_spm_addr_start_o
);

   logic        fetch_en_q;
   logic        cl_rstn_q;
   logic [31:0] llc_start_q;
   logic [31:0] llc_end_q;
   logic [31:0] spm_start_q;

   // Cluster stays in reset until software releases it
   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         fetch_en_q  <= 1'b0;
         cl_rstn_q   <= 1'b0;
         llc_start_q <= periph_reg_pkg::LLC_RESET_VALUE;
         llc_end_q   <= periph_reg_pkg::LLC_RESET_VALUE;
         spm_start_q <= periph_reg_pkg::LLC_RESET_VALUE;
      end else if (we_i) begin
         case (offset_i)
            periph_reg_pkg::SOC_CLUSTER_OFS: begin
               fetch_en_q <= wdata_i[0];
               cl_rstn_q  <= wdata_i[1];
            end
            periph_reg_pkg::SOC_LLC_START_OFS: llc_start_q <= wdata_i;
            periph_reg_pkg::SOC_LLC_END_OFS:   llc_end_q   <= wdata_i;
            periph_reg_pkg::SOC_SPM_START_OFS: spm_start_q <= wdata_i;
            default: ;
         endcase
      end
   end

   always_comb begin
      case (offset_i)
         periph_reg_pkg::SOC_CLUSTER_OFS:   rdata_o = {30'b0, cl_rstn_q, fetch_en_q};
         periph_reg_pkg::SOC_LLC_START_OFS: rdata_o = llc_start_q;
         periph_reg_pkg::SOC_LLC_END_OFS:   rdata_o = llc_end_q;
         periph_reg_pkg::SOC_SPM_START_OFS: rdata_o = spm_start_q;
         default:                           rdata_o = '0;
      endcase
   end

   assign cluster_fetch_en_o     = fetch_en_q;
   assign cluster_rstn_o         = cl_rstn_q;
   assign llc_cache_addr_start_o = llc_start_q;
   assign llc_cache_addr_end_o   = llc_end_q;
   assign llc_spm_addr_start_o   = spm_start_q;

endmodule

/* hw/apb_periph_subsystem.sv */
// ====================
// APB peripheral subsystem top with GPIO, PWM timer and SoC control
// ====================
`timescale 1ns/1ps

module apb_periph_subsystem #(
   parameter int unsigned NUM_GPIO      = 16,
   parameter int unsigned NUM_PWM       = 2,
   parameter int unsigned PWM_CNT_WIDTH = 16
) (
   input  logic                                    clk_i,
   input  logic                                    rst_n_i,
   input  logic [apb_bus_pkg::APB_ADDR_WIDTH-1:0]  paddr_i,
   input  logic                                    psel_i,
   input  logic                                    penable_i,
   input  logic                                    pwrite_i,
   input  logic [apb_bus_pkg::APB_DATA_WIDTH-1:0]  pwdata_i,
   output logic [apb_bus_pkg::APB_DATA_WIDTH-1:0]  prdata_o,
   output logic                                    pready_o,
   output logic                                    pslverr_o,
   input  logic [NUM_GPIO-1:0]                     gpio_in_i,
   output logic [NUM_GPIO-1:0]                     gpio_out_o,
   output logic [NUM_GPIO-1:0]                     gpio_oe_o,
   output logic [NUM_PWM-1:0]                      pwm_o,
   output logic                                    cluster_fetch_en_o,
   output logic                                    cluster_rstn_o,
   output logic [31:0]                             llc_cache_addr_start_o,
   output logic [31:0]                             llc_cache_addr_end_o,
   output logic [31:0]                             llc_spm_addr_start_o
);

   logic [7:0]  reg_offset;
   logic [31:0] reg_wdata;
   logic        gpio_we, pwm_we, soc_we;
   logic [31:0] gpio_rdata, pwm_rdata, soc_rdata;

   apb_xfer_fsm u_fsm (
      .clk_i        (clk_i),
      .rst_n_i      (rst_n_i),
      .paddr_i      (paddr_i),
      .psel_i       (psel_i),
      .penable_i    (penable_i),
      .pwrite_i     (pwrite_i),
      .pwdata_i     (pwdata_i),
      .gpio_rdata_i (gpio_rdata),
      .pwm_rdata_i  (pwm_rdata),
      .soc_rdata_i  (soc_rdata),
      .prdata_o     (prdata_o),
      .pready_o     (pready_o),
      .pslverr_o    (pslverr_o),
      .reg_offset_o (reg_offset),
      .reg_wdata_o  (reg_wdata),
      .gpio_we_o    (gpio_we),
      .pwm_we_o     (pwm_we),
      .soc_we_o     (soc_we)
   );

   gpio_regs #(.NUM_GPIO(NUM_GPIO)) u_gpio (
      .clk_i      (clk_i),
      .rst_n_i    (rst_n_i),
      .we_i       (gpio_we),
      .offset_i   (reg_offset),
      .wdata_i    (reg_wdata),
      .gpio_in_i  (gpio_in_i),
      .rdata_o    (gpio_rdata),
      .gpio_out_o (gpio_out_o),
      .gpio_oe_o  (gpio_oe_o)
   );

   pwm_timer #(
      .NUM_PWM       (NUM_PWM),
      .PWM_CNT_WIDTH (PWM_CNT_WIDTH)
   ) u_pwm (
      .clk_i    (clk_i),
      .rst_n_i  (rst_n_i),
      .we_i     (pwm_we),
      .offset_i (reg_offset),
      .wdata_i  (reg_wdata),
      .rdata_o  (pwm_rdata),
      .pwm_o    (pwm_o)
   );

   soc_ctrl_regs u_soc (
      .clk_i                  (clk_i),
      .rst_n_i                (rst_n_i),
      .we_i                   (soc_we),
      .offset_i               (reg_offset),
      .wdata_i                (reg_wdata),
      .rdata_o                (soc_rdata),
      .cluster_fetch_en_o     (cluster_fetch_en_o),
      .cluster_rstn_o         (cluster_rstn_o),
      .llc_cache_addr_start_o (llc_cache_addr_start_o),
      .llc_cache_addr_end_o   (llc_cache_addr_end_o),
      .llc_spm_addr_start_o   (llc_spm_addr_start_o)
   );

endmodule

/* tests/tb_clk_gen.sv */
// ====================
// Testbench clock and synchronous reset source
// ====================
`timescale 1ns/1ps

module tb_clk_gen #(
   parameter int unsigned PERIOD_NS    = 100,
   parameter int unsigned RESET_CYCLES = 10,
   parameter int unsigned DRIVE_DELAY  = 10
) (
   output logic clk_o,
   output logic rst_n_o
);

   initial begin
      clk_o = 1'b0;
      forever #(PERIOD_NS / 2) clk_o = ~clk_o;
   end

   // Released just after an edge, like the other DUT inputs
   initial begin
      rst_n_o = 1'b0;
      repeat (RESET_CYCLES) @(posedge clk_o);
      #(DRIVE_DELAY);
      rst_n_o = 1'b1;
   end

endmodule

/* tests/tb_apb_periph_assert.sv */
// ====================
// Concurrent checks on the APB port and the PWM waveforms
// Bound into the subsystem top, failures are counted for the testbench
// ====================
`timescale 1ns/1ps

module tb_apb_periph_assert #(
   parameter int unsigned NUM_GPIO      = 16,
   parameter int unsigned NUM_PWM       = 2,
   parameter int unsigned PWM_CNT_WIDTH = 16
) (
   input logic                clk_i,
   input logic                rst_n_i,
   input logic [11:0]         paddr_i,
   input logic                psel_i,
   input logic                penable_i,
   input logic                pwrite_i,
   input logic [31:0]         pwdata_i,
   input logic [31:0]         prdata_i,
   input logic                pready_i,
   input logic                pslverr_i,
   input logic [NUM_PWM-1:0]  pwm_i,
   input logic [NUM_GPIO-1:0] gpio_oe_i,
   input logic [NUM_GPIO-1:0] gpio_out_i,
   input logic [1:0]          cluster_i,
   input logic [95:0]         llc_i
);

   int unsigned              fail_cnt = 0;
   logic                     pwm_en_q;
   logic [PWM_CNT_WIDTH-1:0] period_q;
   logic [PWM_CNT_WIDTH-1:0] duty_q [NUM_PWM];
   int unsigned              settle_q;
   logic                     access;
   logic                     unmapped;
   logic                     pwm_wr;
   logic                     steady;

   assign access   = psel_i && penable_i;
   assign unmapped = !(paddr_i[11:8] inside {apb_bus_pkg::GPIO_BASE[11:8],
                                             apb_bus_pkg::PWM_BASE[11:8],
                                             apb_bus_pkg::SOCCTRL_BASE[11:8]});
   assign pwm_wr   = access && pwrite_i && paddr_i[11:8] == apb_bus_pkg::PWM_BASE[11:8];
   // Waveform has settled two full PWM cycles after the last timer write
   assign steady   = pwm_en_q && settle_q > 2 * (32'(period_q) + 1) + 2;

   // Timer settings as seen on the bus
   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         pwm_en_q <= 1'b0;
         period_q <= '0;
         settle_q <= 0;
         for (int i = 0; i < NUM_PWM; i++) duty_q[i] <= '0;
      end else if (pwm_wr) begin
         settle_q <= 0;
         if (paddr_i[7:0] == periph_reg_pkg::PWM_CTRL_OFS) pwm_en_q <= pwdata_i[0];
         if (paddr_i[7:0] == periph_reg_pkg::PWM_PERIOD_OFS)
            period_q <= pwdata_i[PWM_CNT_WIDTH-1:0];
         for (int i = 0; i < NUM_PWM; i++) begin
            if (paddr_i[7:0] == periph_reg_pkg::PWM_DUTY_OFS + 8'(4 * i))
               duty_q[i] <= pwdata_i[PWM_CNT_WIDTH-1:0];
         end
      end else begin
         settle_q <= settle_q + 1;
      end
   end

   a_pready: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      pready_i == access)
      else begin
         fail_cnt++;
         $error("pready is not high exactly in the access cycle");
      end

   a_slverr: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      pslverr_i == (access && unmapped))
      else begin
         fail_cnt++;
         $error("pslverr does not match the address decode");
      end

   a_err_rdata: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      pslverr_i |-> prdata_i == '0)
      else begin
         fail_cnt++;
         $error("read data is not zero on an error response");
      end

   a_err_quiet: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      pslverr_i |=> $stable(gpio_oe_i) && $stable(gpio_out_i) && $stable(cluster_i)
                    && $stable(llc_i))
      else begin
         fail_cnt++;
         $error("an output changed after an unmapped access");
      end

   a_pwm_off: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      !pwm_en_q |-> pwm_i == '0)
      else begin
         fail_cnt++;
         $error("PWM output is high while the timer is disabled");
      end

   for (genvar ch = 0; ch < NUM_PWM; ch++) begin : g_chan
      logic        prev_q;
      logic        run_ok_q;
      int unsigned run_q;
      int unsigned duty;
      int unsigned cycle;

      assign duty  = 32'(duty_q[ch]);
      assign cycle = 32'(period_q) + 1;

      // Length of the current level, valid once it started in steady state
      always_ff @(posedge clk_i) begin
         if (!rst_n_i) begin
            prev_q   <= 1'b0;
            run_q    <= 0;
            run_ok_q <= 1'b0;
         end else begin
            prev_q <= pwm_i[ch];
            run_q  <= (pwm_i[ch] != prev_q) ? 1 : run_q + 1;
            if (!steady) run_ok_q <= 1'b0;
            else if (pwm_i[ch] != prev_q) run_ok_q <= 1'b1;
         end
      end

      a_run: assert property (@(posedge clk_i) disable iff (!rst_n_i)
         steady && run_ok_q && pwm_i[ch] != prev_q
         |-> run_q == (prev_q ? duty : cycle - duty))
         else begin
            fail_cnt++;
            $error("PWM channel %0d high or low time is wrong", ch);
         end

      a_flat: assert property (@(posedge clk_i) disable iff (!rst_n_i)
         steady && (duty == 0 || duty >= cycle) |-> pwm_i[ch] == (duty != 0))
         else begin
            fail_cnt++;
            $error("PWM channel %0d is not constant for its duty", ch);
         end
   end

endmodule

bind apb_periph_subsystem tb_apb_periph_assert #(
   .NUM_GPIO      (NUM_GPIO),
   .NUM_PWM       (NUM_PWM),
   .PWM_CNT_WIDTH (PWM_CNT_WIDTH)
) u_assert (
   .clk_i      (clk_i),
   .rst_n_i    (rst_n_i),
   .paddr_i    (paddr_i),
   .psel_i     (psel_i),
   .penable_i  (penable_i),
   .pwrite_i   (pwrite_i),
   .pwdata_i   (pwdata_i),
   .prdata_i   (prdata_o),
   .pready_i   (pready_o),
   .pslverr_i  (pslverr_o),
   .pwm_i      (pwm_o),
   .gpio_oe_i  (gpio_oe_o),
   .gpio_out_i (gpio_out_o),
   .cluster_i  ({cluster_rstn_o, cluster_fetch_en_o}),
   .llc_i      ({llc_cache_addr_start_o, llc_cache_addr_end_o, llc_spm_addr_start_o})
);

/* tests/tb_apb_periph.sv */
// ====================
// Testbench for the APB peripheral subsystem
// Runs APB transfers into all three regions and prints the result
// ====================
`timescale 1ns/1ps

module tb_apb_periph;

   localparam int unsigned NUM_GPIO      = 16;
   localparam int unsigned NUM_PWM       = 2;
   localparam int unsigned PWM_CNT_WIDTH = 16;
   localparam int unsigned DRIVE_DELAY   = 10;
   localparam int unsigned SAMPLE_DELAY  = 40;
   localparam int unsigned MAX_WAITS     = 8;
   // Whole run is a few hundred cycles, plenty of margin here
   localparam int unsigned WATCHDOG_CYCLES = 4000;
   localparam logic [31:0] GPIO_MASK       = (32'h1 << NUM_GPIO) - 1;

   logic                clk;
   logic                rst_n;
   logic [11:0]         paddr;
   logic                psel;
   logic                penable;
   logic                pwrite;
   logic [31:0]         pwdata;
   logic [31:0]         prdata;
   logic                pready;
   logic                pslverr;
   logic [NUM_GPIO-1:0] gpio_in;
   logic [NUM_GPIO-1:0] gpio_out;
   logic [NUM_GPIO-1:0] gpio_oe;
   logic [NUM_PWM-1:0]  pwm;
   logic                fetch_en;
   logic                cl_rstn;
   logic [31:0]         llc_start;
   logic [31:0]         llc_end;
   logic [31:0]         spm_start;
   int unsigned         errors = 0;
   int unsigned         checks = 0;

   tb_clk_gen #(.PERIOD_NS(100), .RESET_CYCLES(10), .DRIVE_DELAY(DRIVE_DELAY)) u_clk (
      .clk_o   (clk),
      .rst_n_o (rst_n)
   );

   apb_periph_subsystem #(
      .NUM_GPIO      (NUM_GPIO),
      .NUM_PWM       (NUM_PWM),
      .PWM_CNT_WIDTH (PWM_CNT_WIDTH)
   ) u_dut (
      .clk_i                  (clk),
      .rst_n_i                (rst_n),
      .paddr_i                (paddr),
      .psel_i                 (psel),
      .penable_i              (penable),
      .pwrite_i               (pwrite),
      .pwdata_i               (pwdata),
      .prdata_o               (prdata),
      .pready_o               (pready),
      .pslverr_o              (pslverr),
      .gpio_in_i              (gpio_in),
      .gpio_out_o             (gpio_out),
      .gpio_oe_o              (gpio_oe),
      .pwm_o                  (pwm),
      .cluster_fetch_en_o     (fetch_en),
      .cluster_rstn_o         (cl_rstn),
      .llc_cache_addr_start_o (llc_start),
      .llc_cache_addr_end_o   (llc_end),
      .llc_spm_addr_start_o   (spm_start)
   );

   function automatic logic [11:0] reg_addr(input logic [11:0] base, input logic [7:0] ofs);
      return base | 12'(ofs);
   endfunction

   function automatic logic [11:0] duty_addr(input int ch);
      return reg_addr(apb_bus_pkg::PWM_BASE, periph_reg_pkg::PWM_DUTY_OFS + 8'(4 * ch));
   endfunction

   task automatic check_value(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
      checks++;
      assert (got === exp)
         else begin
            errors++;
            $display("mismatch at %0t: %s is %h, expected %h", $time, name, got, exp);
         end
   endtask

   task automatic wait_cycles(input int unsigned n);
      repeat (n) @(posedge clk);
      #(DRIVE_DELAY);
   endtask

   // One setup cycle, then access until pready
   task automatic apb_xfer(input logic [11:0] addr, input logic write,
                           input logic [31:0] wdata, output logic [31:0] rdata);
      int unsigned waits;
      waits = 0;
      @(posedge clk);
      #(DRIVE_DELAY);
      paddr   = addr;
      pwrite  = write;
      pwdata  = wdata;
      psel    = 1'b1;
      penable = 1'b0;
      @(posedge clk);
      #(DRIVE_DELAY);
      penable = 1'b1;
      #(SAMPLE_DELAY);
      while (!pready && waits < MAX_WAITS) begin
         @(posedge clk);
         #(DRIVE_DELAY + SAMPLE_DELAY);
         waits++;
      end
      if (!pready) begin
         errors++;
         $display("no pready from the DUT for the transfer to address %h", addr);
      end
      rdata = prdata;
      @(posedge clk);
      #(DRIVE_DELAY);
      psel    = 1'b0;
      penable = 1'b0;
      pwrite  = 1'b0;
   endtask

   task automatic apb_write(input logic [11:0] addr, input logic [31:0] data);
      logic [31:0] unused;
      apb_xfer(addr, 1'b1, data, unused);
   endtask

   task automatic apb_read(input logic [11:0] addr, input logic [31:0] exp, input string name);
      logic [31:0] got;
      apb_xfer(addr, 1'b0, 32'h0, got);
      check_value(name, got, exp);
   endtask

   initial begin
      repeat (WATCHDOG_CYCLES) @(posedge clk);
      $display("watchdog expired after %0d cycles, the test did not complete", WATCHDOG_CYCLES);
      $display("Finished with errors");
      $finish;
   end

   initial begin
      logic [31:0] dir;
      logic [31:0] out;
      logic [31:0] din;
      logic [31:0] val;
      logic [31:0] llc_val [3];
      int unsigned period;
      int unsigned duty;
      int unsigned assert_fails;
      paddr   = '0;
      psel    = 1'b0;
      penable = 1'b0;
      pwrite  = 1'b0;
      pwdata  = '0;
      gpio_in = '0;
      void'($urandom(32'h9e46));

      wait (rst_n === 1'b1);
      wait_cycles(1);
      check_value("pready_o", 32'(pready), 32'h0);
      check_value("pslverr_o", 32'(pslverr), 32'h0);
      check_value("pwm_o", 32'(pwm), 32'h0);
      check_value("gpio_oe_o", 32'(gpio_oe), 32'h0);
      check_value("gpio_out_o", 32'(gpio_out), 32'h0);
      check_value("cluster_fetch_en_o", 32'(fetch_en), 32'h0);
      check_value("cluster_rstn_o", 32'(cl_rstn), 32'h0);
      check_value("llc_cache_addr_start_o", llc_start, periph_reg_pkg::LLC_RESET_VALUE);
      check_value("llc_cache_addr_end_o", llc_end, periph_reg_pkg::LLC_RESET_VALUE);
      check_value("llc_spm_addr_start_o", spm_start, periph_reg_pkg::LLC_RESET_VALUE);

      // GPIO
      dir = $urandom;
      out = $urandom;
      apb_write(reg_addr(apb_bus_pkg::GPIO_BASE, periph_reg_pkg::GPIO_DIR_OFS), dir);
      check_value("gpio_oe_o", 32'(gpio_oe), dir & GPIO_MASK);
      apb_write(reg_addr(apb_bus_pkg::GPIO_BASE, periph_reg_pkg::GPIO_OUT_OFS), out);
      check_value("gpio_out_o", 32'(gpio_out), out & dir & GPIO_MASK);
      apb_read(reg_addr(apb_bus_pkg::GPIO_BASE, periph_reg_pkg::GPIO_DIR_OFS),
               dir & GPIO_MASK, "gpio DIR");
      apb_read(reg_addr(apb_bus_pkg::GPIO_BASE, periph_reg_pkg::GPIO_OUT_OFS),
               out & GPIO_MASK, "gpio OUT");
      din = $urandom;
      gpio_in = din[NUM_GPIO-1:0];
      wait_cycles(2);
      apb_read(reg_addr(apb_bus_pkg::GPIO_BASE, periph_reg_pkg::GPIO_IN_OFS),
               din & GPIO_MASK, "gpio IN");
      apb_read(reg_addr(apb_bus_pkg::GPIO_BASE, 8'h40), 32'h0, "gpio empty offset");

      // SoC control
      val = $urandom;
      apb_write(reg_addr(apb_bus_pkg::SOCCTRL_BASE, periph_reg_pkg::SOC_CLUSTER_OFS), val);
      check_value("cluster_fetch_en_o", 32'(fetch_en), 32'(val[0]));
      check_value("cluster_rstn_o", 32'(cl_rstn), 32'(val[1]));
      apb_read(reg_addr(apb_bus_pkg::SOCCTRL_BASE, periph_reg_pkg::SOC_CLUSTER_OFS),
               {30'b0, val[1:0]}, "soc CLUSTER");
      for (int i = 0; i < 3; i++) llc_val[i] = $urandom;
      apb_write(reg_addr(apb_bus_pkg::SOCCTRL_BASE, periph_reg_pkg::SOC_LLC_START_OFS),
                llc_val[0]);
      check_value("llc_cache_addr_start_o", llc_start, llc_val[0]);
      apb_write(reg_addr(apb_bus_pkg::SOCCTRL_BASE, periph_reg_pkg::SOC_LLC_END_OFS),
                llc_val[1]);
      check_value("llc_cache_addr_end_o", llc_end, llc_val[1]);
      apb_write(reg_addr(apb_bus_pkg::SOCCTRL_BASE, periph_reg_pkg::SOC_SPM_START_OFS),
                llc_val[2]);
      check_value("llc_spm_addr_start_o", spm_start, llc_val[2]);
      apb_read(reg_addr(apb_bus_pkg::SOCCTRL_BASE, periph_reg_pkg::SOC_LLC_START_OFS),
               llc_val[0], "soc LLC_START");
      apb_read(reg_addr(apb_bus_pkg::SOCCTRL_BASE, periph_reg_pkg::SOC_LLC_END_OFS),
               llc_val[1], "soc LLC_END");
      apb_read(reg_addr(apb_bus_pkg::SOCCTRL_BASE, periph_reg_pkg::SOC_SPM_START_OFS),
               llc_val[2], "soc SPM_START");
      apb_write(reg_addr(apb_bus_pkg::SOCCTRL_BASE, periph_reg_pkg::SOC_CLUSTER_OFS), 32'h3);
      check_value("cluster_fetch_en_o", 32'(fetch_en), 32'h1);
      check_value("cluster_rstn_o", 32'(cl_rstn), 32'h1);

      // Outside all regions
      // Offset 04 is a live register in every region
      apb_write(12'h304, $urandom);
      apb_read(12'hF00, 32'h0, "unmapped read");

      // PWM, first flat channels, then toggling ones
      period = 4 + ($urandom % 8);
      apb_write(reg_addr(apb_bus_pkg::PWM_BASE, periph_reg_pkg::PWM_PERIOD_OFS), period);
      apb_write(duty_addr(0), 32'h0);
      apb_write(duty_addr(1), period + 1 + ($urandom % 3));
      apb_write(reg_addr(apb_bus_pkg::PWM_BASE, periph_reg_pkg::PWM_CTRL_OFS), 32'h1);
      wait_cycles(6 * (period + 1) + 8);
      apb_read(reg_addr(apb_bus_pkg::PWM_BASE, periph_reg_pkg::PWM_PERIOD_OFS),
               period, "pwm PERIOD");
      apb_read(duty_addr(0), 32'h0, "pwm DUTY0");
      duty = 1 + ($urandom % period);
      apb_write(duty_addr(0), duty);
      apb_write(duty_addr(1), 1 + ($urandom % period));
      wait_cycles(6 * (period + 1) + 8);
      apb_read(duty_addr(0), duty, "pwm DUTY0");
      apb_read(reg_addr(apb_bus_pkg::PWM_BASE, periph_reg_pkg::PWM_CTRL_OFS), 32'h1, "pwm CTRL");
      apb_write(reg_addr(apb_bus_pkg::PWM_BASE, periph_reg_pkg::PWM_CTRL_OFS), 32'h0);
      check_value("pwm_o", 32'(pwm), 32'h0);
      wait_cycles(period + 4);
      check_value("pwm_o", 32'(pwm), 32'h0);

      wait_cycles(4);
      assert_fails = u_dut.u_assert.fail_cnt;
      $display("checks %0d, testbench errors %0d, assertion failures %0d",
               checks, errors, assert_fails);
      if (errors == 0 && assert_fails == 0) begin
         $display("Finished with no errors");
      end else begin
         $display("Finished with errors");
      end
      $finish;
   end

endmodule

/* all.f */
hw/apb_bus_pkg.sv
hw/periph_reg_pkg.sv
hw/apb_xfer_fsm.sv
hw/pwm_timer.sv
hw/gpio_regs.sv
hw/soc_ctrl_regs.sv
hw/apb_periph_subsystem.sv
tests/tb_clk_gen.sv
tests/tb_apb_periph_assert.sv
tests/tb_apb_periph.sv

/* Bender.yml */
package:
  name: apb_periph_subsystem

sources:
  - hw/apb_bus_pkg.sv
  - hw/periph_reg_pkg.sv
  - hw/apb_xfer_fsm.sv
  - hw/pwm_timer.sv
  - hw/gpio_regs.sv
  - hw/soc_ctrl_regs.sv
  - hw/apb_periph_subsystem.sv
  - target: test
    files:
      - tests/tb_clk_gen.sv
      - tests/tb_apb_periph_assert.sv
      - tests/tb_apb_periph.sv
